//--- hw/dp_pkg.sv
package dp_pkg;

    localparam int data_width = 32;
    localparam int reg_addr_width = 4;

    typedef logic [data_width-1:0] word_t;
    typedef logic [reg_addr_width-1:0] reg_addr_t;
    typedef logic [4:0] shamt_t;

    // data-processing opcodes kept by the core
    typedef enum logic [3:0] {
        op_and = 4'b0000,
        op_eor = 4'b0001,
        op_sub = 4'b0010,
        op_add = 4'b0100,
        op_orr = 4'b1100,
        op_mov = 4'b1101,
        op_bic = 4'b1110
    } opcode_t;

    typedef enum logic [1:0] {
        sh_lsl = 2'b00,
        sh_lsr = 2'b01,
        sh_asr = 2'b10,
        sh_ror = 2'b11
    } shift_t;

    // operand 2, read as a 12-bit immediate when the I bit is set
    typedef union packed {
        logic [11:0] imm;
        struct packed {
            shamt_t    shamt;
            shift_t    shift;
            logic      reserved;
            reg_addr_t rm;
        } rsh;
    } operand2_u;

    typedef struct packed {
        logic [3:0] cond;
        logic [1:0] op;
        logic       i;
        opcode_t    opcode;
        logic       s;
        reg_addr_t  rn;
        reg_addr_t  rd;
        operand2_u  op2;
    } instr_t;

endpackage

//--- hw/instr_queue.sv
`timescale 1ns/1ns

module instr_queue import dp_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   instr_valid,
    input  instr_t instr,
    input  logic   q_pop,
    output logic   q_valid,
    output instr_t q_instr,
    output logic   instr_credit
);
    localparam int ptr_width = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int count_width = $clog2(QUEUE_DEPTH + 1);

    instr_t buffer [QUEUE_DEPTH];
    logic [ptr_width-1:0] wr_ptr;
    logic [ptr_width-1:0] rd_ptr;
    logic [count_width-1:0] count;
    logic push;

    // wrap at the depth, which need not be a power of two
    function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
        if (ptr == ptr_width'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // sender only writes while holding a credit, so full never sees a push
    assign push = instr_valid && (count != count_width'(QUEUE_DEPTH));
    assign q_valid = (count != '0);
    assign q_instr = buffer[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            buffer[wr_ptr] <= instr;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            instr_credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (q_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + count_width'(push) - count_width'(q_pop);
            // one credit back per slot freed
            instr_credit <= q_pop;
        end
    end

endmodule

//--- hw/reg_file.sv
`timescale 1ns/1ns

module reg_file import dp_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t ra1,
    input  reg_addr_t ra2,
    input  logic      we,
    input  reg_addr_t wa,
    input  word_t     wd,
    output word_t     rd1,
    output word_t     rd2
);
    localparam int num_regs = 1 << reg_addr_width;

    word_t regs [num_regs];

    // r0..r15 are all general purpose here, no pc alias
    assign rd1 = regs[ra1];
    assign rd2 = regs[ra2];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wa] <= wd;
        end
    end

endmodule

//--- hw/issue_stage.sv
`timescale 1ns/1ns

module issue_stage import dp_pkg::*; #(
    parameter int RESULT_CREDITS = 2
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      q_valid,
    input  instr_t    q_instr,
    input  logic      res_credit,
    input  word_t     ex_result,
    input  logic      we,
    input  reg_addr_t wa,
    input  word_t     wd,
    output logic      q_pop,
    output logic      ex_valid,
    output reg_addr_t ex_rd,
    output logic      ex_write,
    output logic      ex_use_shift,
    output opcode_t   ex_opcode,
    output shift_t    ex_shift,
    output shamt_t    ex_shamt,
    output word_t     ex_rn_value,
    output word_t     ex_opb_value,
    output word_t     ex_rm_value
);
    localparam int credit_width = $clog2(RESULT_CREDITS + 1);

    logic [credit_width-1:0] credit_count;
    word_t rd1;
    word_t rd2;
    word_t rn_value;
    word_t rm_value;
    logic fwd_rn;
    logic fwd_rm;
    logic supported;

    reg_file u_regs (
        .clk(clk), .reset(reset),
        .ra1(q_instr.rn), .ra2(q_instr.op2.rsh.rm),
        .we(we), .wa(wa), .wd(wd),
        .rd1(rd1), .rd2(rd2)
    );

    ////////////////////////////////////////////////////////////////////////////
    // operand read and forwarding

    // only the execute register can hold a pending write, older ones are in the file
    assign fwd_rn = ex_valid && ex_write && (ex_rd == q_instr.rn);
    assign fwd_rm = ex_valid && ex_write && (ex_rd == q_instr.op2.rsh.rm);
    assign rn_value = fwd_rn ? ex_result : rd1;
    assign rm_value = fwd_rm ? ex_result : rd2;

    always_comb begin
        case (q_instr.opcode)
            op_and, op_eor, op_sub, op_add, op_orr, op_mov, op_bic: supported = 1'b1;
            default: supported = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // result credits and issue

    assign q_pop = q_valid && (credit_count != '0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            credit_count <= credit_width'(RESULT_CREDITS);
        end else begin
            credit_count <= credit_count + credit_width'(res_credit) - credit_width'(q_pop);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_valid <= 1'b0;
            ex_write <= 1'b0;
            ex_use_shift <= 1'b0;
        end else begin
            ex_valid <= q_pop;
            if (q_pop) begin
                ex_write <= supported && (q_instr.op == 2'b00);
                // shifter only feeds mov in register form
                ex_use_shift <= !q_instr.i && (q_instr.opcode == op_mov);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (q_pop) begin
            ex_rd <= q_instr.rd;
            ex_opcode <= q_instr.opcode;
            ex_shift <= q_instr.op2.rsh.shift;
            ex_shamt <= q_instr.op2.rsh.shamt;
            ex_rn_value <= rn_value;
            ex_rm_value <= rm_value;
            // zero-extended 12-bit immediate
            ex_opb_value <= q_instr.i ? word_t'(q_instr.op2.imm) : rm_value;
        end
    end

endmodule

//--- hw/barrel_shifter.sv
`timescale 1ns/1ns

module barrel_shifter import dp_pkg::*; (
    input  word_t  ex_rm_value,
    input  shift_t ex_shift,
    input  shamt_t ex_shamt,
    output word_t  shift_result
);
    logic [2*data_width-1:0] doubled;
    logic [2*data_width-1:0] rotated;

    // rotate as a right shift of the word placed twice
    assign doubled = {ex_rm_value, ex_rm_value};
    assign rotated = doubled >> ex_shamt;

    // amount 0 leaves rm unchanged for every shift type
    always_comb begin
        case (ex_shift)
            sh_lsl: shift_result = ex_rm_value << ex_shamt;
            sh_lsr: shift_result = ex_rm_value >> ex_shamt;
            sh_asr: shift_result = word_t'($signed(ex_rm_value) >>> ex_shamt);
            default: shift_result = rotated[data_width-1:0];
        endcase
    end

endmodule

//--- hw/alu.sv
`timescale 1ns/1ns

module alu import dp_pkg::*; (
    input  opcode_t ex_opcode,
    input  word_t   ex_rn_value,
    input  word_t   ex_opb_value,
    output word_t   alu_result
);

    always_comb begin
        case (ex_opcode)
            op_and: alu_result = ex_rn_value & ex_opb_value;
            op_eor: alu_result = ex_rn_value ^ ex_opb_value;
            op_sub: alu_result = ex_rn_value - ex_opb_value;
            op_add: alu_result = ex_rn_value + ex_opb_value;
            op_orr: alu_result = ex_rn_value | ex_opb_value;
            // mov ignores rn
            op_mov: alu_result = ex_opb_value;
            op_bic: alu_result = ex_rn_value & ~ex_opb_value;
            // unsupported opcodes report zero
            default: alu_result = '0;
        endcase
    end

endmodule

//--- hw/result_stage.sv
`timescale 1ns/1ns

module result_stage import dp_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      ex_valid,
    input  reg_addr_t ex_rd,
    input  logic      ex_write,
    input  logic      ex_use_shift,
    input  word_t     shift_result,
    input  word_t     alu_result,
    output word_t     ex_result,
    output logic      we,
    output reg_addr_t wa,
    output word_t     wd,
    output logic      res_valid,
    output word_t     res_data,
    output reg_addr_t res_rd
);

    assign ex_result = ex_use_shift ? shift_result : alu_result;

    // register file write lands on the same edge as the result register
    assign we = ex_valid && ex_write;
    assign wa = ex_rd;
    assign wd = ex_result;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= ex_valid;
        end
    end

    // unsupported ops still emit a result, just without the write
    always_ff @(posedge clk) begin
        if (ex_valid) begin
            res_data <= ex_result;
            res_rd <= ex_rd;
        end
    end

endmodule

//--- hw/dp_core.sv
`timescale 1ns/1ns

module dp_core import dp_pkg::*; #(
    parameter int QUEUE_DEPTH = 4,
    parameter int RESULT_CREDITS = 2
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      instr_valid,
    input  instr_t    instr,
    input  logic      res_credit,
    output logic      instr_credit,
    output logic      res_valid,
    output word_t     res_data,
    output reg_addr_t res_rd
);
    // queue to issue
    logic q_valid;
    instr_t q_instr;
    logic q_pop;

    // execute register
    logic ex_valid;
    reg_addr_t ex_rd;
    logic ex_write;
    logic ex_use_shift;
    opcode_t ex_opcode;
    shift_t ex_shift;
    shamt_t ex_shamt;
    word_t ex_rn_value;
    word_t ex_opb_value;
    word_t ex_rm_value;

    // execute results and write-back
    word_t shift_result;
    word_t alu_result;
    word_t ex_result;
    logic rf_we;
    reg_addr_t rf_wa;
    word_t rf_wd;

    ////////////////////////////////////////////////////////////////////////////
    // front end

    instr_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
        .clk, .reset, .instr_valid, .instr, .q_pop,
        .q_valid, .q_instr, .instr_credit
    );

    issue_stage #(.RESULT_CREDITS(RESULT_CREDITS)) u_issue (
        .clk, .reset, .q_valid, .q_instr, .res_credit, .ex_result,
        .we(rf_we), .wa(rf_wa), .wd(rf_wd),
        .q_pop, .ex_valid, .ex_rd, .ex_write, .ex_use_shift,
        .ex_opcode, .ex_shift, .ex_shamt,
        .ex_rn_value, .ex_opb_value, .ex_rm_value
    );

    ////////////////////////////////////////////////////////////////////////////
    // execute and write-back

    barrel_shifter u_shifter (
        .ex_rm_value, .ex_shift, .ex_shamt, .shift_result
    );

    alu u_alu (
        .ex_opcode, .ex_rn_value, .ex_opb_value, .alu_result
    );

    result_stage u_result (
        .clk, .reset, .ex_valid, .ex_rd, .ex_write, .ex_use_shift,
        .shift_result, .alu_result, .ex_result,
        .we(rf_we), .wa(rf_wa), .wd(rf_wd),
        .res_valid, .res_data, .res_rd
    );

endmodule

//--- verification/dp_core_checker.sv
`timescale 1ns/1ns

module dp_core_checker #(
    parameter int QUEUE_DEPTH = 4,
    parameter int RESULT_CREDITS = 2
) (
    input logic                                  clk,
    input logic                                  reset,
    input logic                                  instr_valid,
    input logic                                  res_valid,
    input logic [$clog2(QUEUE_DEPTH+1)-1:0]      queue_count,
    input logic [$clog2(RESULT_CREDITS+1)-1:0]   credit_count
);
    localparam int queue_width = $clog2(QUEUE_DEPTH + 1);
    localparam int credit_width = $clog2(RESULT_CREDITS + 1);

    int failures = 0;

    // sender writes only while it holds a credit
    no_push_when_full: assert property (
        @(posedge clk) disable iff (reset)
        (queue_count == queue_width'(QUEUE_DEPTH)) |-> !instr_valid
    ) else begin
        $error("instruction written while the queue was full");
        failures++;
    end

    credit_in_range: assert property (
        @(posedge clk) disable iff (reset)
        credit_count <= credit_width'(RESULT_CREDITS)
    ) else begin
        $error("result credit count above its start value");
        failures++;
    end

    // pipeline is empty right out of reset
    quiet_after_reset: assert property (
        @(posedge clk) $fell(reset) |=> !res_valid
    ) else begin
        $error("res_valid high in the first cycle after reset");
        failures++;
    end

endmodule

bind dp_core dp_core_checker #(
    .QUEUE_DEPTH(QUEUE_DEPTH),
    .RESULT_CREDITS(RESULT_CREDITS)
) u_checker (
    .clk(clk),
    .reset(reset),
    .instr_valid(instr_valid),
    .res_valid(res_valid),
    .queue_count(u_queue.count),
    .credit_count(u_issue.credit_count)
);

//--- verification/dp_core_tb.sv
`timescale 1ns/1ns

module dp_core_tb import dp_pkg::*; ();

    localparam int clk_period = 4;
    localparam int reset_cycles = 5;
    localparam int queue_depth = 4;
    localparam int max_vectors = 64;
    localparam int cycles_per_vector = 40;
    localparam int drain_cycles = 8;
    localparam logic [31:0] lfsr_seed = 32'h5d08_9088;

    logic clk;
    logic reset;
    logic instr_valid;
    instr_t instr;
    logic res_credit;
    logic instr_credit;
    logic res_valid;
    word_t res_data;
    reg_addr_t res_rd;

    // word 0 is the vector count and then instr, rd and data per vector
    logic [31:0] vectors [0:3*max_vectors];
    logic [31:0] lfsr_state;
    int num_vectors;
    int sent;
    int received;
    int cycle;
    int instr_credits;
    int credit_due [$];

    dp_core u_dut (
        .clk, .reset, .instr_valid, .instr, .res_credit,
        .instr_credit, .res_valid, .res_data, .res_rd
    );

    ////////////////////////////////////////////////////////////////////////////
    // helpers

    // fibonacci lfsr with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic next_random_bit();
        logic feedback;
        feedback = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], feedback};
        return feedback;
    endfunction

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_error(input string reason);
        $display("ERROR at %0t ns: %s", $time, reason);
        abort_run();
    endtask

    task automatic check_data(input word_t actual, input word_t expected, input int index);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: vector %0d res_data %h, expected %h",
                     $time, index, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_rd(input reg_addr_t actual, input reg_addr_t expected, input int index);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: vector %0d res_rd %0d, expected %0d",
                     $time, index, actual, expected);
            abort_run();
        end
    endtask

    // one cycle of sender and receiver 1 ns after the edge
    task automatic service_cycle();
        int due;
        int delay;
        if (u_dut.u_checker.failures != 0) begin
            report_error("a bound assertion on the credit or queue rules failed");
        end
        if (instr_credit) begin
            instr_credits++;
        end
        if (instr_credits > queue_depth) begin
            report_error("more instruction credits came back than the queue holds");
        end
        if (res_valid) begin
            if (received >= num_vectors) begin
                report_error("a result arrived after the last expected one");
            end
            check_rd(res_rd, reg_addr_t'(vectors[3*received+2]), received);
            check_data(res_data, vectors[3*received+3], received);
            received++;
            delay = 0;
            repeat (2) delay = delay * 2 + int'(next_random_bit());
            due = cycle + delay;
            // keep returns ordered with at most one pulse a cycle
            if (credit_due.size() > 0 && due <= credit_due[$]) begin
                due = credit_due[$] + 1;
            end
            credit_due.push_back(due);
        end
        res_credit = 1'b0;
        if (credit_due.size() > 0 && credit_due[0] <= cycle) begin
            void'(credit_due.pop_front());
            res_credit = 1'b1;
        end
        if (sent < num_vectors && instr_credits > 0) begin
            instr_valid = 1'b1;
            instr = instr_t'(vectors[3*sent+1]);
            instr_credits--;
            sent++;
        end else begin
            instr_valid = 1'b0;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // clock, stimulus and watchdog

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        instr_valid = 1'b0;
        instr = '0;
        res_credit = 1'b0;
        lfsr_state = lfsr_seed;
        sent = 0;
        received = 0;
        cycle = 0;
        instr_credits = queue_depth;
        $readmemh("verification/dp_core_vectors.txt", vectors);
        num_vectors = int'(vectors[0]);
        if (num_vectors < 1 || num_vectors > max_vectors) begin
            report_error("vector file is missing, empty or too long for the vector memory");
        end
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;
        while (received < num_vectors) begin
            @(posedge clk);
            #1;
            cycle++;
            service_cycle();
        end
        // nothing extra may come out once the stream is done
        repeat (drain_cycles) begin
            @(posedge clk);
            #1;
            cycle++;
            service_cycle();
        end
        if (instr_credits != queue_depth) begin
            report_error("instruction credits were not all returned");
        end
        if (u_dut.u_checker.failures == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            report_error("a bound assertion on the credit or queue rules failed");
        end
    end

    initial begin
        @(negedge reset);
        repeat (num_vectors * cycles_per_vector) @(posedge clk);
        report_error("results stopped arriving before the watchdog limit");
    end

endmodule

//--- verification/dp_core_vectors.txt
// first word: number of vectors (hex)
// then per line: instruction word, expected res_rd, expected res_data
1f
e3a010ff 1 000000ff // mov r1, #0x0ff
e3a02abc 2 00000abc // mov r2, #0xabc
e2813801 3 00000900 // add r3, r1, #0x801
e382400f 4 00000abf // orr r4, r2, #0x00f
e3a05fff 5 00000fff // mov r5, #0xfff
e0426001 6 000009bd // sub r6, r2, r1
e0417002 7 fffff643 // sub r7, r1, r2
e0048003 8 00000800 // and r8, r4, r3
e0259002 9 00000543 // eor r9, r5, r2
e1c5a004 a 00000540 // bic r10, r5, r4
e1a0b001 b 000000ff // mov r11, r1, lsl #0
e1a0cf81 c 80000000 // mov r12, r1, lsl #31
e1a0d247 d ffffff64 // mov r13, r7, asr #4
e1a0efc7 e ffffffff // mov r14, r7, asr #31
e1a0ffa7 f 00000001 // mov r15, r7, lsr #31
e1a0b262 b c00000ab // mov r11, r2, ror #4
e1a0c427 c 00fffff6 // mov r12, r7, lsr #8
e1a0d061 d 000000ff // mov r13, r1, ror #0
e1a0efe2 e 00001578 // mov r14, r2, ror #31
e1a00047 0 fffff643 // mov r0, r7, asr #0
e2811001 1 00000100 // add r1, r1, #1
e2811100 1 00000200 // add r1, r1, #0x100
e0412000 2 00000bbd // sub r2, r1, r0
e1a03202 3 0000bbd0 // mov r3, r2, lsl #4
e0234002 4 0000b06d // eor r4, r3, r2
e1c44005 4 0000b000 // bic r4, r4, r5
e2616005 6 00000000 // opcode 0011, unsupported
e1a07006 7 000009bd // mov r7, r6
e3868000 8 000009bd // orr r8, r6, #0
e1e09001 9 00000000 // opcode 1111, unsupported
e289a000 a 00000543 // add r10, r9, #0

//--- project.f
hw/dp_pkg.sv
hw/instr_queue.sv
hw/reg_file.sv
hw/issue_stage.sv
hw/barrel_shifter.sv
hw/alu.sv
hw/result_stage.sv
hw/dp_core.sv
verification/dp_core_checker.sv
verification/dp_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= dp_core_tb
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(BUILD_DIR)
